/* hw/dma_pkg.sv */
package dma_pkg;

   // --------------------------------------------------
   // Transmit packet header
   // --------------------------------------------------

   // Packet kind sits in the top two header bits
   typedef enum logic [1:0] {
      PKT_MRD = 2'b00,
      PKT_MWR = 2'b01
   } pkt_kind_e;

   // Read view, tag comes back on the completion
   typedef struct packed {
      pkt_kind_e   kind;
      logic [7:0]  tag;
      logic [5:0]  len;
      logic [47:0] addr;
   } tx_rd_hdr_t;

   // Write view, id is the low byte of the descriptor sequence number
   typedef struct packed {
      pkt_kind_e   kind;
      logic [7:0]  id;
      logic [5:0]  len;
      logic [47:0] addr;
   } tx_wr_hdr_t;

   // One 64-bit header word, decoded by packet kind
   typedef union packed {
      tx_rd_hdr_t rd;
      tx_wr_hdr_t wr;
   } tx_hdr_u;

   // --------------------------------------------------
   // Register map and descriptor layout
   // --------------------------------------------------

   localparam logic [3:0] REG_DW0    = 4'd0;
   localparam logic [3:0] REG_DW1    = 4'd4;
   localparam logic [3:0] REG_DW2    = 4'd8;
   localparam logic [3:0] REG_RCLAST = 4'd12;

   // Bytes per descriptor in host memory
   localparam int unsigned DESC_BYTES = 16;
   // A descriptor read is always two 64-bit words
   localparam logic [5:0] DESC_QW = 6'd2;

   // Completion beat 0: [15:0] length, [31:16] EP address, [63:32] host high
   // Completion beat 1: [31:0] host low
   typedef struct packed {
      logic [15:0] len;
      logic [15:0] ep_addr;
      logic [31:0] host_hi;
      logic [31:0] host_lo;
   } desc_t;

endpackage

/* hw/dma_prg_reg.sv */
`timescale 1ns/10ps

module dma_prg_reg (
   input  logic        clk_in,
   input  logic        sw_rstn,
   input  logic        prg_wrena,
   input  logic [3:0]  prg_addr,
   input  logic [31:0] prg_wrdata,
   output logic [31:0] prg_rddata,
   output logic [15:0] dt_size,
   output logic [63:0] dt_base_rc,
   output logic [15:0] dt_rc_last
);

   // Full words are kept so readback returns what the host wrote
   logic [31:0] dw0_q;
   logic [31:0] dw1_q;
   logic [31:0] dw2_q;
   logic [31:0] rclast_q;

   // --------------------------------------------------
   // Host writes
   // --------------------------------------------------
   always_ff @(posedge clk_in or negedge sw_rstn) begin
      if (!sw_rstn) begin
         dw0_q    <= '0;
         dw1_q    <= '0;
         dw2_q    <= '0;
         rclast_q <= '0;
      end else if (prg_wrena) begin
         case (prg_addr)
            dma_pkg::REG_DW0:    dw0_q    <= prg_wrdata;
            dma_pkg::REG_DW1:    dw1_q    <= prg_wrdata;
            dma_pkg::REG_DW2:    dw2_q    <= prg_wrdata;
            dma_pkg::REG_RCLAST: rclast_q <= prg_wrdata;
            default: ;
         endcase
      end
   end

   // Readback follows the offset with no register stage
   always_comb begin
      case (prg_addr)
         dma_pkg::REG_DW0:    prg_rddata = dw0_q;
         dma_pkg::REG_DW1:    prg_rddata = dw1_q;
         dma_pkg::REG_DW2:    prg_rddata = dw2_q;
         dma_pkg::REG_RCLAST: prg_rddata = rclast_q;
         default:             prg_rddata = '0;
      endcase
   end

   // Table size in DW0 low half, base is DW1:DW2
   assign dt_size    = dw0_q[15:0];
   assign dt_base_rc = {dw1_q, dw2_q};
   assign dt_rc_last = rclast_q[15:0];

endmodule

/* hw/dma_descriptor_fetch.sv */
`timescale 1ns/10ps

module dma_descriptor_fetch #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic             clk_in,
   input  logic             sw_rstn,
   input  logic [15:0]      dt_size,
   input  logic [63:0]      dt_base_rc,
   input  logic [15:0]      dt_rc_last,
   input  logic             req_ready,
   input  logic             rx_valid,
   input  logic [7:0]       rx_tag,
   input  logic [63:0]      rx_data,
   input  logic             rx_last,
   input  logic             desc_pop,
   output logic             req_valid,
   output dma_pkg::tx_hdr_u req_hdr,
   output logic [63:0]      req_data,
   output logic             req_last,
   output logic             desc_valid,
   output dma_pkg::desc_t   desc
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // FSM states, one fetch in flight at most
   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_REQ  = 2'd1;
   localparam logic [1:0] S_CPL  = 2'd2;

   logic [1:0]       state;
   logic [15:0]      fetch_cnt;
   logic [15:0]      tbl_idx;
   logic [63:0]      desc_addr;
   logic [63:0]      beat0_q;
   logic             start;
   logic             cpl_hit;
   logic             push;
   logic             pop;
   dma_pkg::desc_t   new_desc;
   dma_pkg::desc_t   fifo_mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fifo_cnt;

   // Table slot address, index wraps at the table size
   assign desc_addr = dt_base_rc + 64'(tbl_idx) * 64'(dma_pkg::DESC_BYTES);

   // New fetch when RCLAST is ahead and the FIFO has a free slot
   assign start   = (state == S_IDLE) && (fetch_cnt != dt_rc_last) &&
                    (fifo_cnt < CNT_W'(FIFO_DEPTH));
   assign cpl_hit = (state == S_CPL) && rx_valid && (rx_tag == req_hdr.rd.tag);
   assign push    = cpl_hit && rx_last;
   assign pop     = desc_pop && desc_valid;

   // MRd is a single header-only beat
   assign req_valid = (state == S_REQ);
   assign req_data  = '0;
   assign req_last  = 1'b1;

   // --------------------------------------------------
   // Fetch control
   // --------------------------------------------------
   always_ff @(posedge clk_in or negedge sw_rstn) begin
      if (!sw_rstn) begin
         state     <= S_IDLE;
         fetch_cnt <= '0;
         tbl_idx   <= '0;
      end else begin
         case (state)
            S_IDLE: if (start) state <= S_REQ;
            S_REQ: begin
               if (req_ready) begin
                  fetch_cnt <= fetch_cnt + 16'd1;
                  tbl_idx   <= (tbl_idx + 16'd1 >= dt_size) ? '0 : tbl_idx + 16'd1;
                  state     <= S_CPL;
               end
            end
            // Completion wait ends on the matching last beat
            S_CPL: if (push) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Header is frozen for the whole request
   always_ff @(posedge clk_in) begin
      if (start) begin
         req_hdr.rd.kind <= dma_pkg::PKT_MRD;
         req_hdr.rd.tag  <= fetch_cnt[7:0];
         req_hdr.rd.len  <= dma_pkg::DESC_QW;
         req_hdr.rd.addr <= desc_addr[47:0];
      end
      if (cpl_hit && !rx_last) beat0_q <= rx_data;
   end

   // Assemble from the held first beat and the last beat
   always_comb begin
      new_desc.len     = beat0_q[15:0];
      new_desc.ep_addr = beat0_q[31:16];
      new_desc.host_hi = beat0_q[63:32];
      new_desc.host_lo = rx_data[31:0];
   end

   // --------------------------------------------------
   // Descriptor FIFO
   // --------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (push) fifo_mem[wr_ptr] <= new_desc;
   end

   always_ff @(posedge clk_in or negedge sw_rstn) begin
      if (!sw_rstn) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_cnt <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // Simultaneous push and pop leave the count alone
         if (push && !pop) fifo_cnt <= fifo_cnt + 1'b1;
         else if (pop && !push) fifo_cnt <= fifo_cnt - 1'b1;
      end
   end

   assign desc_valid = (fifo_cnt != '0);
   assign desc       = fifo_mem[rd_ptr];

endmodule

/* hw/dma_write_requester.sv */
`timescale 1ns/10ps

module dma_write_requester #(
   parameter int MAX_PAYLOAD_QW = 8,
   parameter int MEM_AW         = 12
) (
   input  logic              clk_in,
   input  logic              sw_rstn,
   input  logic              desc_valid,
   input  dma_pkg::desc_t    desc,
   input  logic              req_ready,
   input  logic [63:0]       mem_rd_data,
   output logic              desc_pop,
   output logic              req_valid,
   output dma_pkg::tx_hdr_u  req_hdr,
   output logic [63:0]       req_data,
   output logic              req_last,
   output logic [MEM_AW-1:0] mem_rd_addr,
   output logic [15:0]       done_count
);

   localparam logic [15:0] MAX_W = 16'(MAX_PAYLOAD_QW);

   // FSM states
   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_LOAD = 2'd1;
   localparam logic [1:0] S_SEND = 2'd2;

   logic [1:0]        state;
   logic [MEM_AW-1:0] rd_ptr;
   logic [MEM_AW-1:0] rd_ptr_nxt;
   logic [63:0]       hold_q;
   logic [5:0]        beat_cnt;
   logic [15:0]       rem_len;
   logic [15:0]       chunk_src;
   logic [5:0]        chunk;
   logic              beat_acc;
   logic              pkt_end;

   // Packet length, capped at the max payload
   function automatic logic [5:0] chunk_of(input logic [15:0] words);
      if (words > MAX_W) begin
         return MAX_W[5:0];
      end
      return words[5:0];
   endfunction

   assign beat_acc  = req_valid && req_ready;
   assign pkt_end   = beat_acc && req_last;
   // First packet sized from the new descriptor, later ones from the remainder
   assign chunk_src = (state == S_IDLE) ? desc.len : rem_len;
   assign chunk     = chunk_of(chunk_src);

   assign req_valid = (state == S_SEND);
   assign req_last  = (beat_cnt == 6'd1);
   assign req_data  = hold_q;

   // Pop on the final beat, zero-length descriptors retire at once
   assign desc_pop = ((state == S_IDLE) && desc_valid && (desc.len == '0)) ||
                     (pkt_end && (rem_len == '0));

   // --------------------------------------------------
   // Local memory read pointer
   // --------------------------------------------------
   // Address is presented one word ahead, so mem_rd_data is the word at rd_ptr
   always_comb begin
      rd_ptr_nxt = rd_ptr;
      if ((state == S_IDLE) && desc_valid) begin
         rd_ptr_nxt = desc.ep_addr[MEM_AW-1:0];
      end else if ((state == S_LOAD) || beat_acc) begin
         rd_ptr_nxt = rd_ptr + 1'b1;
      end
   end

   assign mem_rd_addr = rd_ptr_nxt;

   // --------------------------------------------------
   // Packet control
   // --------------------------------------------------
   always_ff @(posedge clk_in or negedge sw_rstn) begin
      if (!sw_rstn) begin
         state      <= S_IDLE;
         rd_ptr     <= '0;
         beat_cnt   <= '0;
         rem_len    <= '0;
         done_count <= '0;
      end else begin
         rd_ptr <= rd_ptr_nxt;
         case (state)
            S_IDLE: begin
               if (desc_valid && (desc.len == '0)) begin
                  done_count <= done_count + 16'd1;
               end else if (desc_valid) begin
                  rem_len  <= desc.len - 16'(chunk);
                  beat_cnt <= chunk;
                  state    <= S_LOAD;
               end
            end
            // First word arrives from memory here
            S_LOAD: state <= S_SEND;
            S_SEND: begin
               if (beat_acc && !req_last) begin
                  beat_cnt <= beat_cnt - 6'd1;
               end else if (pkt_end && (rem_len != '0)) begin
                  // Next packet of the same descriptor follows directly
                  rem_len  <= rem_len - 16'(chunk);
                  beat_cnt <= chunk;
               end else if (pkt_end) begin
                  done_count <= done_count + 16'd1;
                  state      <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Header and data word, held steady while stalled
   always_ff @(posedge clk_in) begin
      if ((state == S_IDLE) && desc_valid) begin
         req_hdr.wr.kind <= dma_pkg::PKT_MWR;
         req_hdr.wr.id   <= done_count[7:0];
         req_hdr.wr.len  <= chunk;
         req_hdr.wr.addr <= {desc.host_hi[15:0], desc.host_lo};
      end else if (pkt_end && (rem_len != '0)) begin
         // Host address moves on by 8 bytes per word sent
         req_hdr.wr.addr <= req_hdr.wr.addr + {39'd0, req_hdr.wr.len, 3'b000};
         req_hdr.wr.len  <= chunk;
      end
      if ((state == S_LOAD) || beat_acc) hold_q <= mem_rd_data;
   end

endmodule

/* hw/dma_tx_arbiter.sv */
`timescale 1ns/10ps

module dma_tx_arbiter (
   input  logic        clk_in,
   input  logic        sw_rstn,
   input  logic        a_valid,
   input  logic [63:0] a_hdr,
   input  logic [63:0] a_data,
   input  logic        a_last,
   input  logic        b_valid,
   input  logic [63:0] b_hdr,
   input  logic [63:0] b_data,
   input  logic        b_last,
   input  logic        tx_ready,
   output logic        a_ready,
   output logic        b_ready,
   output logic        tx_valid,
   output logic [63:0] tx_hdr,
   output logic [63:0] tx_data,
   output logic        tx_last
);

   logic grant_b;
   logic locked;
   logic own_valid;
   logic other_valid;
   logic beat_acc;
   logic switch_grant;

   // Owner drives the bus combinationally
   assign own_valid   = grant_b ? b_valid : a_valid;
   assign other_valid = grant_b ? a_valid : b_valid;

   assign tx_valid = own_valid;
   assign tx_hdr   = grant_b ? b_hdr : a_hdr;
   assign tx_data  = grant_b ? b_data : a_data;
   assign tx_last  = grant_b ? b_last : a_last;
   assign a_ready  = !grant_b && tx_ready;
   assign b_ready  = grant_b && tx_ready;

   assign beat_acc = tx_valid && tx_ready;

   // Hand over after a finished packet, or when the idle owner leaves a waiter
   assign switch_grant = other_valid &&
                         ((beat_acc && tx_last) || (!locked && !own_valid));

   // --------------------------------------------------
   // Grant and packet lock
   // --------------------------------------------------
   always_ff @(posedge clk_in or negedge sw_rstn) begin
      if (!sw_rstn) begin
         grant_b <= 1'b0;
         locked  <= 1'b0;
      end else begin
         if (switch_grant) grant_b <= !grant_b;
         // Lock covers a multi-beat packet until its last beat
         if (beat_acc) locked <= !tx_last;
      end
   end

endmodule

/* hw/dma_dt.sv */
`timescale 1ns/10ps

module dma_dt #(
   parameter int MAX_PAYLOAD_QW = 8,
   parameter int FIFO_DEPTH     = 4,
   parameter int MEM_AW         = 12
) (
   input  logic              clk_in,
   input  logic              sw_rstn,
   // Register port
   input  logic              prg_wrena,
   input  logic [3:0]        prg_addr,
   input  logic [31:0]       prg_wrdata,
   output logic [31:0]       prg_rddata,
   // Transmit bus
   output logic              tx_valid,
   output logic [63:0]       tx_hdr,
   output logic [63:0]       tx_data,
   output logic              tx_last,
   input  logic              tx_ready,
   // Completions, always accepted
   input  logic              rx_valid,
   input  logic [7:0]        rx_tag,
   input  logic [63:0]       rx_data,
   input  logic              rx_last,
   // Local endpoint memory
   output logic [MEM_AW-1:0] mem_rd_addr,
   input  logic [63:0]       mem_rd_data,
   // EPLAST
   output logic [15:0]       done_count
);

   // --------------------------------------------------
   // Internal wiring
   // --------------------------------------------------
   logic [15:0]      dt_size;
   logic [63:0]      dt_base_rc;
   logic [15:0]      dt_rc_last;

   logic             fetch_valid;
   logic             fetch_ready;
   dma_pkg::tx_hdr_u fetch_hdr;
   logic [63:0]      fetch_data;
   logic             fetch_last;

   logic             wr_valid;
   logic             wr_ready;
   dma_pkg::tx_hdr_u wr_hdr;
   logic [63:0]      wr_data;
   logic             wr_last;

   logic             desc_valid;
   logic             desc_pop;
   dma_pkg::desc_t   desc;

   dma_prg_reg u_prg_reg (
      .clk_in     (clk_in),
      .sw_rstn    (sw_rstn),
      .prg_wrena  (prg_wrena),
      .prg_addr   (prg_addr),
      .prg_wrdata (prg_wrdata),
      .prg_rddata (prg_rddata),
      .dt_size    (dt_size),
      .dt_base_rc (dt_base_rc),
      .dt_rc_last (dt_rc_last)
   );

   // Descriptor fetcher, requester a on the arbiter
   dma_descriptor_fetch #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fetch (
      .clk_in     (clk_in),
      .sw_rstn    (sw_rstn),
      .dt_size    (dt_size),
      .dt_base_rc (dt_base_rc),
      .dt_rc_last (dt_rc_last),
      .req_ready  (fetch_ready),
      .rx_valid   (rx_valid),
      .rx_tag     (rx_tag),
      .rx_data    (rx_data),
      .rx_last    (rx_last),
      .desc_pop   (desc_pop),
      .req_valid  (fetch_valid),
      .req_hdr    (fetch_hdr),
      .req_data   (fetch_data),
      .req_last   (fetch_last),
      .desc_valid (desc_valid),
      .desc       (desc)
   );

   // Payload writer, requester b
   dma_write_requester #(
      .MAX_PAYLOAD_QW (MAX_PAYLOAD_QW),
      .MEM_AW         (MEM_AW)
   ) u_write_req (
      .clk_in      (clk_in),
      .sw_rstn     (sw_rstn),
      .desc_valid  (desc_valid),
      .desc        (desc),
      .req_ready   (wr_ready),
      .mem_rd_data (mem_rd_data),
      .desc_pop    (desc_pop),
      .req_valid   (wr_valid),
      .req_hdr     (wr_hdr),
      .req_data    (wr_data),
      .req_last    (wr_last),
      .mem_rd_addr (mem_rd_addr),
      .done_count  (done_count)
   );

   dma_tx_arbiter u_arbiter (
      .clk_in   (clk_in),
      .sw_rstn  (sw_rstn),
      .a_valid  (fetch_valid),
      .a_hdr    (fetch_hdr),
      .a_data   (fetch_data),
      .a_last   (fetch_last),
      .b_valid  (wr_valid),
      .b_hdr    (wr_hdr),
      .b_data   (wr_data),
      .b_last   (wr_last),
      .tx_ready (tx_ready),
      .a_ready  (fetch_ready),
      .b_ready  (wr_ready),
      .tx_valid (tx_valid),
      .tx_hdr   (tx_hdr),
      .tx_data  (tx_data),
      .tx_last  (tx_last)
   );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int RESET_CYCLES = 4
) (
   output logic clk_in,
   output logic sw_rstn
);

   // 10 ns period, first rising edge at 5 ns
   initial begin
      clk_in = 1'b0;
      forever #5 clk_in = ~clk_in;
   end

   // Reset held low, then released on a rising edge
   initial begin
      sw_rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_in);
      sw_rstn <= 1'b1;
   end

endmodule

/* tests/dma_dt_assert.sv */
`timescale 1ns/10ps

module dma_dt_assert (
   input logic        clk_in,
   input logic        sw_rstn,
   input logic        tx_valid,
   input logic        tx_ready,
   input logic [63:0] tx_hdr,
   input logic [63:0] tx_data,
   input logic        tx_last,
   input logic        rx_valid,
   input logic [7:0]  rx_tag,
   input logic        rx_last,
   input logic [15:0] done_count
);

   dma_pkg::tx_hdr_u hdr;
   logic             mrd_acc;
   logic             cpl_pend;
   logic [7:0]       pend_tag;

   assign hdr     = tx_hdr;
   assign mrd_acc = tx_valid && tx_ready && (hdr.rd.kind == dma_pkg::PKT_MRD);

   // Fetch stays open until the last completion beat with its tag
   always_ff @(posedge clk_in or negedge sw_rstn) begin
      if (!sw_rstn) begin
         cpl_pend <= 1'b0;
         pend_tag <= '0;
      end else if (mrd_acc) begin
         cpl_pend <= 1'b1;
         pend_tag <= hdr.rd.tag;
      end else if (rx_valid && rx_last && (rx_tag == pend_tag)) begin
         cpl_pend <= 1'b0;
      end
   end

   // Stalled beat keeps header, data and last
   a_tx_stable: assert property (@(posedge clk_in) disable iff (!sw_rstn)
      (tx_valid && !tx_ready) |=> ($stable(tx_hdr) && $stable(tx_data) && $stable(tx_last)))
      else $error("transmit beat changed while stalled");

   // Valid stays up until the beat is taken
   a_tx_hold: assert property (@(posedge clk_in) disable iff (!sw_rstn)
      (tx_valid && !tx_ready) |=> tx_valid)
      else $error("tx_valid dropped before the beat was accepted");

   // EPLAST only counts up
   a_done_up: assert property (@(posedge clk_in) disable iff (!sw_rstn)
      done_count >= $past(done_count))
      else $error("done_count decreased");

   // One descriptor fetch in flight at a time
   a_one_fetch: assert property (@(posedge clk_in) disable iff (!sw_rstn)
      mrd_acc |-> !cpl_pend)
      else $error("descriptor read issued while a completion was pending");

endmodule

bind dma_dt dma_dt_assert u_assert (
   .clk_in     (clk_in),
   .sw_rstn    (sw_rstn),
   .tx_valid   (tx_valid),
   .tx_ready   (tx_ready),
   .tx_hdr     (tx_hdr),
   .tx_data    (tx_data),
   .tx_last    (tx_last),
   .rx_valid   (rx_valid),
   .rx_tag     (rx_tag),
   .rx_last    (rx_last),
   .done_count (done_count)
);

/* tests/tb_dma_dt.sv */
`timescale 1ns/10ps

module tb_dma_dt;

   localparam int MAX_PAYLOAD_QW = 8;
   localparam int FIFO_DEPTH     = 4;
   localparam int MEM_AW         = 12;
   // Host table storage, only the first tbl_size entries are used
   localparam int TBL_MAX        = 8;
   localparam int N_STEPS        = 4;

   logic              clk_in;
   logic              sw_rstn;
   logic              prg_wrena;
   logic [3:0]        prg_addr;
   logic [31:0]       prg_wrdata;
   logic [31:0]       prg_rddata;
   logic              tx_valid;
   logic [63:0]       tx_hdr;
   logic [63:0]       tx_data;
   logic              tx_last;
   logic              tx_ready    = 1'b0;
   logic              rx_valid    = 1'b0;
   logic [7:0]        rx_tag      = '0;
   logic [63:0]       rx_data     = '0;
   logic              rx_last     = 1'b0;
   logic [MEM_AW-1:0] mem_rd_addr;
   logic [63:0]       mem_rd_data = '0;
   logic [15:0]       done_count;

   // Host descriptor table
   logic [15:0]       tbl_len [TBL_MAX];
   logic [15:0]       tbl_ep  [TBL_MAX];
   logic [31:0]       tbl_hi  [TBL_MAX];
   logic [31:0]       tbl_lo  [TBL_MAX];
   logic [63:0]       tbl_base;
   int unsigned       tbl_size;
   int unsigned       rclast_cur;

   // Scoreboard state
   int unsigned       n_checks   = 0;
   int unsigned       n_errors   = 0;
   int unsigned       n_timeouts = 0;
   int unsigned       fetch_seq  = 0;
   int unsigned       wr_seq     = 0;
   int unsigned       wr_off     = 0;
   int unsigned       pkt_beat   = 0;
   int unsigned       pkt_len    = 0;
   logic [63:0]       pkt_hdr    = '0;

   // Completion responder
   logic [1:0]        cpl_state;
   int unsigned       cpl_wait;
   logic [7:0]        cpl_tag;
   int unsigned       cpl_idx;

   dma_pkg::tx_hdr_u  bus_hdr;
   logic [47:0]       req_off;

   assign bus_hdr = tx_hdr;
   assign req_off = bus_hdr.rd.addr - tbl_base[47:0];

   tb_clock #(
      .RESET_CYCLES (4)
   ) u_clock (
      .clk_in  (clk_in),
      .sw_rstn (sw_rstn)
   );

   dma_dt #(
      .MAX_PAYLOAD_QW (MAX_PAYLOAD_QW),
      .FIFO_DEPTH     (FIFO_DEPTH),
      .MEM_AW         (MEM_AW)
   ) dut (
      .clk_in      (clk_in),
      .sw_rstn     (sw_rstn),
      .prg_wrena   (prg_wrena),
      .prg_addr    (prg_addr),
      .prg_wrdata  (prg_wrdata),
      .prg_rddata  (prg_rddata),
      .tx_valid    (tx_valid),
      .tx_hdr      (tx_hdr),
      .tx_data     (tx_data),
      .tx_last     (tx_last),
      .tx_ready    (tx_ready),
      .rx_valid    (rx_valid),
      .rx_tag      (rx_tag),
      .rx_data     (rx_data),
      .rx_last     (rx_last),
      .mem_rd_addr (mem_rd_addr),
      .mem_rd_data (mem_rd_data),
      .done_count  (done_count)
   );

   // --------------------------------------------------
   // Reference rules
   // --------------------------------------------------
   // Both halves carry the address so every bit of it shows in the data
   function automatic logic [63:0] mem_word(input logic [MEM_AW-1:0] a);
      return {20'hA5C3E, a, 20'h1B2D4, ~a};
   endfunction

   // Table slot of fetch number seq
   function automatic logic [47:0] fetch_addr(input int unsigned seq);
      logic [63:0] a;
      a = tbl_base + 64'(dma_pkg::DESC_BYTES * (seq % tbl_size));
      return a[47:0];
   endfunction

   task automatic check_val(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // One accepted MWr beat against the descriptor being written
   task automatic check_mwr_beat();
      int unsigned idx;
      int unsigned rem;
      logic [47:0] host;
      idx = wr_seq % tbl_size;
      if (pkt_beat == 0) begin
         rem     = 32'(tbl_len[idx]) - wr_off;
         pkt_len = (rem > 32'(MAX_PAYLOAD_QW)) ? 32'(MAX_PAYLOAD_QW) : rem;
         host    = {tbl_hi[idx][15:0], tbl_lo[idx]} + 48'(wr_off * 8);
         pkt_hdr = tx_hdr;
         check_val(64'(wr_seq < fetch_seq), 64'd1, "MWr before its descriptor fetch");
         check_val(64'(bus_hdr.wr.id), 64'(wr_seq % 256), "MWr descriptor id");
         check_val(64'(bus_hdr.wr.len), 64'(pkt_len), "MWr length");
         check_val(64'(bus_hdr.wr.addr), 64'(host), "MWr host address");
      end else begin
         check_val(tx_hdr, pkt_hdr, "MWr header within packet");
      end
      check_val(tx_data, mem_word(MEM_AW'(32'(tbl_ep[idx]) + wr_off)), "MWr data");
      check_val(64'(tx_last), 64'(pkt_beat + 1 == pkt_len), "MWr last flag");
      wr_off   = wr_off + 1;
      pkt_beat = pkt_beat + 1;
      if (pkt_beat == pkt_len) pkt_beat = 0;
      // Descriptor finished, next one in sequence
      if (wr_off >= 32'(tbl_len[idx])) begin
         wr_seq   = wr_seq + 1;
         wr_off   = 0;
         pkt_beat = 0;
      end
   endtask

   // --------------------------------------------------
   // Bus models
   // --------------------------------------------------
   // Local memory, one cycle read latency
   always @(posedge clk_in) begin
      mem_rd_data <= mem_word(mem_rd_addr);
   end

   // Roughly 70 percent ready
   always @(posedge clk_in) begin
      tx_ready <= (($urandom % 100) < 70);
   end

   // Host answers each MRd with a two-beat completion
   always @(posedge clk_in) begin
      if (!sw_rstn) begin
         rx_valid  <= 1'b0;
         rx_last   <= 1'b0;
         cpl_state <= 2'd0;
      end else begin
         rx_valid <= 1'b0;
         rx_last  <= 1'b0;
         case (cpl_state)
            2'd0: begin
               if (tx_valid && tx_ready && (bus_hdr.rd.kind == dma_pkg::PKT_MRD)) begin
                  cpl_tag   <= bus_hdr.rd.tag;
                  cpl_idx   <= 32'(req_off >> 4) % TBL_MAX;
                  cpl_wait  <= 1 + $urandom % 8;
                  cpl_state <= 2'd1;
               end
            end
            // Random latency, then length, EP address and host high
            2'd1: begin
               if (cpl_wait > 1) begin
                  cpl_wait <= cpl_wait - 1;
               end else begin
                  rx_valid  <= 1'b1;
                  rx_tag    <= cpl_tag;
                  rx_data   <= {tbl_hi[cpl_idx], tbl_ep[cpl_idx], tbl_len[cpl_idx]};
                  cpl_state <= 2'd2;
               end
            end
            2'd2: begin
               rx_valid  <= 1'b1;
               rx_last   <= 1'b1;
               rx_tag    <= cpl_tag;
               rx_data   <= {32'h0, tbl_lo[cpl_idx]};
               cpl_state <= 2'd0;
            end
            default: cpl_state <= 2'd0;
         endcase
      end
   end

   // Transmit monitor
   always @(posedge clk_in) begin
      if (sw_rstn && tx_valid && tx_ready) begin
         if (bus_hdr.rd.kind == dma_pkg::PKT_MRD) begin
            check_val(64'(fetch_seq < rclast_cur), 64'd1, "MRd beyond RCLAST");
            check_val(64'(tx_last), 64'd1, "MRd last flag");
            check_val(tx_data, 64'd0, "MRd data");
            check_val(64'(bus_hdr.rd.len), 64'd2, "MRd length");
            check_val(64'(bus_hdr.rd.tag), 64'(fetch_seq % 256), "MRd tag");
            check_val(64'(bus_hdr.rd.addr), 64'(fetch_addr(fetch_seq)), "MRd address");
            fetch_seq = fetch_seq + 1;
         end else begin
            check_val(64'(bus_hdr.wr.kind), 64'(dma_pkg::PKT_MWR), "packet kind");
            check_mwr_beat();
         end
      end
   end

   // --------------------------------------------------
   // Register access and waits
   // --------------------------------------------------
   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
      @(posedge clk_in);
      prg_wrena  <= 1'b1;
      prg_addr   <= addr;
      prg_wrdata <= data;
      @(posedge clk_in);
      prg_wrena  <= 1'b0;
   endtask

   // Readback is combinational, sampled mid-cycle
   task automatic read_check(input logic [3:0] addr, input logic [31:0] exp,
                             input string what);
      @(posedge clk_in);
      prg_addr <= addr;
      @(negedge clk_in);
      check_val(64'(prg_rddata), 64'(exp), what);
   endtask

   task automatic wait_reset();
      int unsigned n;
      n = 0;
      while (!sw_rstn && (n < 20)) begin
         @(posedge clk_in);
         n++;
      end
      if (!sw_rstn) begin
         n_timeouts++;
         $display("timeout: reset was never released");
      end
   endtask

   task automatic wait_done(input int unsigned total);
      int unsigned n;
      n = 0;
      while (((32'(done_count) != total) || (wr_seq != total)) && (n < 4000)) begin
         @(negedge clk_in);
         n++;
      end
      if ((32'(done_count) != total) || (wr_seq != total)) begin
         n_timeouts++;
         $display("timeout: %0d descriptors done and %0d written, expected %0d",
                  done_count, wr_seq, total);
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      int unsigned steps [N_STEPS];
      int unsigned i;
      logic [31:0] dw0;
      void'($urandom(32'h5211));
      steps      = '{2, 6, 11, 19};
      prg_wrena  = 1'b0;
      prg_addr   = '0;
      prg_wrdata = '0;
      // Lengths cover short, exact and multi-packet descriptors
      for (i = 0; i < TBL_MAX; i++) begin
         tbl_len[i] = 16'(1 + $urandom % 20);
         tbl_ep[i]  = 16'($urandom);
         tbl_hi[i]  = $urandom;
         tbl_lo[i]  = $urandom & 32'hFFFF_FFF8;
      end
      tbl_size   = 5;
      tbl_base   = {16'h0000, 16'($urandom), $urandom & 32'hFFFF_FFF0};
      dw0        = {16'($urandom), 16'(tbl_size)};
      rclast_cur = 0;

      wait_reset();
      @(negedge clk_in);
      check_val(64'(tx_valid), 64'd0, "tx_valid after reset");
      check_val(64'(done_count), 64'd0, "done_count after reset");
      read_check(dma_pkg::REG_DW0, 32'd0, "DW0 after reset");
      read_check(dma_pkg::REG_DW1, 32'd0, "DW1 after reset");
      read_check(dma_pkg::REG_DW2, 32'd0, "DW2 after reset");
      read_check(dma_pkg::REG_RCLAST, 32'd0, "RCLAST after reset");

      // Table setup, first RCLAST starts the engine
      write_reg(dma_pkg::REG_DW0, dw0);
      write_reg(dma_pkg::REG_DW1, tbl_base[63:32]);
      write_reg(dma_pkg::REG_DW2, tbl_base[31:0]);
      write_reg(dma_pkg::REG_RCLAST, steps[0]);
      rclast_cur = steps[0];
      read_check(dma_pkg::REG_DW0, dw0, "DW0 readback");
      read_check(dma_pkg::REG_DW1, tbl_base[63:32], "DW1 readback");
      read_check(dma_pkg::REG_DW2, tbl_base[31:0], "DW2 readback");
      read_check(dma_pkg::REG_RCLAST, steps[0], "RCLAST readback");
      check_val(64'(dut.dt_size), 64'(dw0[15:0]), "table size from DW0");

      // RCLAST raised while the engine runs, later steps wrap the table
      for (i = 1; i < N_STEPS; i++) begin
         repeat (20 + $urandom % 40) @(posedge clk_in);
         write_reg(dma_pkg::REG_RCLAST, steps[i]);
         rclast_cur = steps[i];
      end
      wait_done(steps[N_STEPS-1]);

      // Idle time shows nothing runs past RCLAST
      repeat (30) @(negedge clk_in);
      check_val(64'(fetch_seq), 64'(steps[N_STEPS-1]), "descriptor fetches");
      check_val(64'(wr_seq), 64'(steps[N_STEPS-1]), "descriptors written");
      check_val(64'(done_count), 64'(steps[N_STEPS-1]), "final done_count");

      $display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
      if ((n_errors == 0) && (n_timeouts == 0)) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* sources.f */
hw/dma_pkg.sv
hw/dma_prg_reg.sv
hw/dma_descriptor_fetch.sv
hw/dma_write_requester.sv
hw/dma_tx_arbiter.sv
hw/dma_dt.sv
tests/tb_clock.sv
tests/dma_dt_assert.sv
tests/tb_dma_dt.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_dma_dt -f sources.f \
   -o sim_dma_dt > build.log 2>&1 &&
   ./obj_dir/sim_dma_dt > sim.log 2>&1 ||
   echo "*** FAILED ***" >> sim.log
cat sim.log
grep -qF '*** FAILED ***' sim.log && exit 1 || exit 0
